// ==== commit.f ====
verilog/commit_pkg.sv
verilog/mem_stage.sv
verilog/csr_file.sv
verilog/wb_stage.sv
verilog/reg_file.sv
verilog/commit_top.sv
dv/commit_props.sv
dv/commit_tb.sv

// ==== dv/commit_tb.sv ====
`timescale 1ns/1ps

module commit_tb;
    import commit_pkg::*;

    localparam int N_ITEMS = 85;
    localparam int WATCHDOG_CYCLES = N_ITEMS * 40 + 2000;

    logic clk;
    logic resetn;
    logic in_valid;
    logic in_ready;
    retire_req_t in_req;
    logic trace_valid;
    logic trace_ready;
    trace_t trace;
    logic redirect_valid;
    word_t redirect_pc;
    reg_addr_t rf_raddr;
    word_t rf_rdata;

    int errors = 0;
    int checks = 0;
    logic [31:0] lfsr = 32'hdce7;
    word_t pc_next = 32'h1c000000;
    bit seen_full = 0;
    bit bp_on = 0;
    retire_req_t req_q[$];
    bit drop_q[$];
    // reference model state
    word_t m_regs [0:31];
    bit m_wr [0:31];
    word_t m_crmd = 32'h8;
    word_t m_prmd = '0;
    word_t m_estat = '0;
    word_t m_era = '0;
    word_t m_eentry = 32'h1c008000;
    word_t m_save [0:3] = '{default: '0};

    commit_top #(.EENTRY_RESET(32'h1c008000)) commit_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("Regression failed");
        $finish;
    end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic word_t rand_bits(int n);
        word_t v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(string name, word_t got, word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("Fail %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    function automatic word_t csr_model_read(csr_num_t n);
        case (n)
            CSR_CRMD: return m_crmd;
            CSR_PRMD: return m_prmd;
            CSR_ESTAT: return m_estat;
            CSR_ERA: return m_era;
            CSR_EENTRY: return m_eentry;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return m_save[n[1:0]];
            default: return '0;
        endcase
    endfunction

    // writable bits of each csr layout
    function automatic word_t csr_field_mask(csr_num_t n);
        case (n)
            CSR_CRMD: return 32'h1ff;
            CSR_PRMD: return 32'h7;
            CSR_ESTAT: return 32'h3;
            CSR_ERA: return 32'hffffffff;
            CSR_EENTRY: return 32'hffffffc0;
            CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: return 32'hffffffff;
            default: return '0;
        endcase
    endfunction

    task automatic commit_model(retire_req_t r, word_t rdv);
        word_t mk;
        word_t nv;
        mk = r.csr_wmask & csr_field_mask(r.csr_num);
        nv = (rdv & ~mk) | (r.csr_wvalue & mk);
        if (r.rf_we && !r.excep && r.rf_waddr != 0) begin
            m_regs[r.rf_waddr] = r.res_from_csr ? rdv : r.rf_result;
            m_wr[r.rf_waddr] = 1;
        end
        if (r.csr_we && !r.excep) begin
            case (r.csr_num)
                CSR_CRMD: m_crmd = nv;
                CSR_PRMD: m_prmd = nv;
                CSR_ESTAT: m_estat = nv;
                CSR_ERA: m_era = nv;
                CSR_EENTRY: m_eentry = nv;
                CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3: m_save[r.csr_num[1:0]] = nv;
                default: ;
            endcase
        end
        if (r.excep) begin
            m_prmd = {29'b0, m_crmd[2:0]};
            m_crmd[2:0] = 3'b0;
            m_estat[30:16] = {r.esubcode, r.ecode};
            m_era = r.pc;
        end else if (r.ertn) begin
            m_crmd[2:0] = m_prmd[2:0];
        end
    endtask

    // compare each fired trace record with the model
    always @(posedge clk) begin
        retire_req_t r;
        word_t rdv;
        if (resetn && trace_valid && trace_ready) begin
            while (drop_q.size() > 0 && drop_q[0]) begin
                void'(req_q.pop_front());
                void'(drop_q.pop_front());
            end
            assert (req_q.size() > 0) else begin
                $display("trace record appeared with nothing outstanding");
                errors++;
            end
            if (req_q.size() > 0) begin
                r = req_q.pop_front();
                void'(drop_q.pop_front());
                rdv = csr_model_read(r.csr_num);
                check_value("trace.pc", trace.pc, r.pc);
                check_value("trace.rf_we", trace.rf_we, r.rf_we && !r.excep);
                check_value("trace.rf_wnum", trace.rf_wnum, r.rf_waddr);
                check_value("trace.rf_wdata", trace.rf_wdata,
                            r.res_from_csr ? rdv : r.rf_result);
                check_value("redirect_valid", redirect_valid, r.excep || r.ertn);
                if (r.excep || r.ertn) begin
                    check_value("redirect_pc", redirect_pc, r.excep ? m_eentry : m_era);
                end
                commit_model(r, rdv);
                while (drop_q.size() > 0 && drop_q[0] && (r.excep || r.ertn)) begin
                    void'(req_q.pop_front());
                    void'(drop_q.pop_front());
                end
            end
        end else if (resetn) begin
            check_value("redirect_valid", redirect_valid, 1'b0);
        end
        if (in_valid && !in_ready) seen_full = 1;
    end

    task automatic send(retire_req_t r, bit dropped = 0);
        r.pc = pc_next;
        pc_next += 4;
        @(negedge clk);
        in_valid = 1'b1;
        in_req = r;
        do @(posedge clk); while (!in_ready);
        req_q.push_back(r);
        drop_q.push_back(dropped);
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    function automatic retire_req_t csr_op(csr_num_t n, bit we, word_t mask, word_t val,
                                           reg_addr_t rd);
        retire_req_t r = '0;
        r.rf_we = 1;
        r.rf_waddr = rd;
        r.res_from_csr = 1;
        r.csr_num = n;
        r.csr_we = we;
        r.csr_wmask = mask;
        r.csr_wvalue = val;
        return r;
    endfunction

    task automatic drain_and_check_regs();
        int guard;
        guard = 0;
        while (req_q.size() > 0 &&
               !(req_q.size() == drop_q.sum() with (int'(item)) && guard > 20)) begin
            @(posedge clk);
            guard++;
        end
        repeat (3) @(posedge clk);
        for (int i = 0; i < 32; i++) begin
            @(negedge clk);
            rf_raddr = reg_addr_t'(i);
            #1;
            if (i == 0) check_value("rf_rdata[0]", rf_rdata, '0);
            else if (m_wr[i]) check_value($sformatf("rf_rdata[%0d]", i), rf_rdata, m_regs[i]);
        end
    endtask

    task automatic reset_test();
        resetn = 1'b0;
        repeat (10) begin
            @(negedge clk);
            check_value("trace_valid", trace_valid, 1'b0);
            check_value("redirect_valid", redirect_valid, 1'b0);
        end
        resetn = 1'b1;
        @(negedge clk);
        check_value("trace_valid", trace_valid, 1'b0);
        send(csr_op(CSR_CRMD, 0, 0, 0, 5'd1));
        drain_and_check_regs();
    endtask

    task automatic reg_test(int n);
        retire_req_t r;
        for (int i = 0; i < n; i++) begin
            r = '0;
            r.rf_we = 1;
            r.rf_waddr = (i == 3) ? 5'd0 : reg_addr_t'(rand_bits(5));
            r.rf_result = rand_bits(32);
            send(r);
        end
        drain_and_check_regs();
    endtask

    task automatic backpressure_test(int n);
        seen_full = 0;
        bp_on = 1;
        fork
            begin
                reg_test(n);
                bp_on = 0;
            end
            while (bp_on) begin
                @(negedge clk);
                trace_ready = (rand_bits(1) != 0);
            end
        join
        trace_ready = 1'b1;
        assert (seen_full) else begin
            $display("in_ready never fell while the stages were full");
            errors++;
        end
    endtask

    task automatic csr_test();
        for (int i = 0; i < 4; i++) begin
            send(csr_op(csr_num_t'(CSR_SAVE0 + i), 1, rand_bits(32), rand_bits(32),
                        reg_addr_t'(10 + i)));
        end
        for (int i = 0; i < 4; i++) begin
            send(csr_op(csr_num_t'(CSR_SAVE0 + i), 0, 0, 0, reg_addr_t'(14 + i)));
        end
        send(csr_op(CSR_CRMD, 0, 0, 0, 5'd18));
        send(csr_op(14'h7, 1, 32'hffffffff, 32'h5a5a5a5a, 5'd19));
        drain_and_check_regs();
    endtask

    task automatic exception_test();
        retire_req_t r;
        send(csr_op(CSR_CRMD, 1, 32'h7, 32'h7, 5'd20));
        drain_and_check_regs();
        @(negedge clk);
        trace_ready = 1'b0;
        r = '0;
        r.rf_we = 1;
        r.rf_waddr = 5'd21;
        r.rf_result = 32'hdeadbeef;
        r.excep = 1;
        r.ecode = 6'hb;
        r.esubcode = 9'h3;
        send(r);
        r.excep = 0;
        r.rf_waddr = 5'd22;
        send(r, 1);
        @(negedge clk);
        trace_ready = 1'b1;
        send(csr_op(CSR_ERA, 0, 0, 0, 5'd23));
        send(csr_op(CSR_PRMD, 0, 0, 0, 5'd24));
        send(csr_op(CSR_ESTAT, 0, 0, 0, 5'd25));
        drain_and_check_regs();
    endtask

    task automatic ertn_test();
        retire_req_t r;
        send(csr_op(CSR_PRMD, 1, 32'h7, 32'h5, 5'd26));
        send(csr_op(CSR_ERA, 1, 32'hffffffff, 32'h1c001234, 5'd27));
        r = '0;
        r.ertn = 1;
        send(r);
        send(csr_op(CSR_CRMD, 0, 0, 0, 5'd28));
        drain_and_check_regs();
    endtask

    initial begin
        resetn = 1'b0;
        in_valid = 1'b0;
        in_req = '0;
        trace_ready = 1'b1;
        rf_raddr = '0;
        for (int i = 0; i < 32; i++) m_wr[i] = 0;
        reset_test();
        reg_test(24);
        backpressure_test(40);
        csr_test();
        exception_test();
        ertn_test();
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== dv/commit_props.sv ====
`timescale 1ns/1ps

module commit_props (
    input logic               clk,
    input logic               resetn,
    input logic               trace_valid,
    input logic               trace_ready,
    input commit_pkg::trace_t trace,
    input logic               redirect_valid,
    input commit_pkg::rf_wr_t rf_wr
);
    import commit_pkg::*;

    // held record stays stable until taken
    trace_stable: assert property (@(posedge clk) disable iff (!resetn)
        trace_valid && !trace_ready |=> trace_valid && $stable(trace))
        else $error("trace changed while held without trace_ready");

    redirect_fires: assert property (@(posedge clk) disable iff (!resetn)
        redirect_valid |-> trace_valid && trace_ready)
        else $error("redirect_valid outside a firing cycle");

    write_fires: assert property (@(posedge clk) disable iff (!resetn)
        rf_wr.we |-> trace_valid && trace_ready)
        else $error("register write outside a firing cycle");

endmodule

bind wb_stage commit_props commit_props_i (.*);

// ==== verilog/commit_top.sv ====
`timescale 1ns/1ps

module commit_top #(
    parameter commit_pkg::word_t EENTRY_RESET = 32'h1c008000
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  commit_pkg::retire_req_t in_req,
    output logic                    trace_valid,
    input  logic                    trace_ready,
    output commit_pkg::trace_t      trace,
    output logic                    redirect_valid,
    output commit_pkg::word_t       redirect_pc,
    input  commit_pkg::reg_addr_t   rf_raddr,
    output commit_pkg::word_t       rf_rdata
);
    import commit_pkg::*;

    logic        mem_valid;
    retire_req_t mem_req;
    logic        wb_allowin;
    logic        flush;
    rf_wr_t      rf_wr;

    mem_stage mem_stage_i (
        .clk        (clk),
        .resetn     (resetn),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_req     (in_req),
        .flush      (flush),
        .wb_allowin (wb_allowin),
        .mem_valid  (mem_valid),
        .mem_req    (mem_req)
    );

    wb_stage #(
        .EENTRY_RESET (EENTRY_RESET)
    ) wb_stage_i (
        .clk            (clk),
        .resetn         (resetn),
        .mem_valid      (mem_valid),
        .mem_req        (mem_req),
        .wb_allowin     (wb_allowin),
        .flush          (flush),
        .rf_wr          (rf_wr),
        .trace_valid    (trace_valid),
        .trace          (trace),
        .trace_ready    (trace_ready),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .rf_wr    (rf_wr),
        .rf_raddr (rf_raddr),
        .rf_rdata (rf_rdata)
    );

endmodule

// ==== verilog/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  commit_pkg::rf_wr_t    rf_wr,
    input  commit_pkg::reg_addr_t rf_raddr,
    output commit_pkg::word_t     rf_rdata
);
    import commit_pkg::*;

    word_t regs [0:31];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (rf_wr.we && rf_wr.waddr != '0) begin
            regs[rf_wr.waddr] <= rf_wr.wdata;
        end
    end

    assign rf_rdata = (rf_raddr == '0) ? '0 : regs[rf_raddr];

endmodule

// ==== verilog/wb_stage.sv ====
`timescale 1ns/1ps

module wb_stage #(
    parameter commit_pkg::word_t EENTRY_RESET = 32'h1c008000
) (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    mem_valid,
    input  commit_pkg::retire_req_t mem_req,
    output logic                    wb_allowin,
    output logic                    flush,
    output commit_pkg::rf_wr_t      rf_wr,
    output logic                    trace_valid,
    output commit_pkg::trace_t      trace,
    input  logic                    trace_ready,
    output logic                    redirect_valid,
    output commit_pkg::word_t       redirect_pc
);
    import commit_pkg::*;

    logic        wb_valid;
    retire_req_t wb_req;
    logic        fire;
    logic        ex_commit;
    logic        ertn_commit;
    logic        csr_we_commit;
    logic        rf_we_eff;
    word_t       csr_rvalue;
    word_t       rf_wdata;

    // completes only once the trace record is taken
    assign trace_valid = wb_valid;
    assign fire        = wb_valid && trace_ready;
    assign wb_allowin  = !wb_valid || fire;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_valid && wb_allowin) begin
            wb_req <= mem_req;
        end
    end

    // exception wins over ertn when both are set
    assign ex_commit     = fire && wb_req.excep;
    assign ertn_commit   = fire && wb_req.ertn && !wb_req.excep;
    assign csr_we_commit = fire && wb_req.csr_we && !wb_req.excep;

    assign redirect_valid = ex_commit || ertn_commit;
    assign flush          = redirect_valid;

    csr_file #(
        .EENTRY_RESET (EENTRY_RESET)
    ) csr_file_i (
        .clk         (clk),
        .resetn      (resetn),
        .csr_num     (wb_req.csr_num),
        .csr_we      (csr_we_commit),
        .csr_wmask   (wb_req.csr_wmask),
        .csr_wvalue  (wb_req.csr_wvalue),
        .ex_commit   (ex_commit),
        .ertn_commit (ertn_commit),
        .ecode       (wb_req.ecode),
        .esubcode    (wb_req.esubcode),
        .pc          (wb_req.pc),
        .csr_rvalue  (csr_rvalue),
        .redirect_pc (redirect_pc)
    );

    // a faulting instruction leaves the register file alone
    assign rf_we_eff = wb_req.rf_we && !wb_req.excep;
    assign rf_wdata  = wb_req.res_from_csr ? csr_rvalue : wb_req.rf_result;

    assign rf_wr.we    = fire && rf_we_eff;
    assign rf_wr.waddr = wb_req.rf_waddr;
    assign rf_wr.wdata = rf_wdata;

    assign trace.pc       = wb_req.pc;
    assign trace.rf_we    = rf_we_eff;
    assign trace.rf_wnum  = wb_req.rf_waddr;
    assign trace.rf_wdata = rf_wdata;

endmodule

// ==== verilog/csr_file.sv ====
`timescale 1ns/1ps

module csr_file #(
    parameter commit_pkg::word_t EENTRY_RESET = 32'h1c008000
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  commit_pkg::csr_num_t  csr_num,
    input  logic                  csr_we,
    input  commit_pkg::word_t     csr_wmask,
    input  commit_pkg::word_t     csr_wvalue,
    input  logic                  ex_commit,
    input  logic                  ertn_commit,
    input  commit_pkg::ecode_t    ecode,
    input  commit_pkg::esubcode_t esubcode,
    input  commit_pkg::word_t     pc,
    output commit_pkg::word_t     csr_rvalue,
    output commit_pkg::word_t     redirect_pc
);
    import commit_pkg::*;

    // crmd fields
    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic        crmd_da;
    logic        crmd_pg;
    logic [1:0]  crmd_datf;
    logic [1:0]  crmd_datm;
    // prmd fields
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    // estat fields, only is[1:0] is software writable
    logic [1:0]  estat_is_sw;
    ecode_t      estat_ecode;
    esubcode_t   estat_esubcode;
    word_t       era;
    logic [25:0] eentry_va;
    word_t       save_r [0:3];

    word_t crmd_value;
    word_t prmd_value;
    word_t estat_value;
    word_t eentry_value;
    word_t merged;

    assign crmd_value   = {23'b0, crmd_datm, crmd_datf, crmd_pg, crmd_da, crmd_ie, crmd_plv};
    assign prmd_value   = {29'b0, prmd_pie, prmd_pplv};
    assign estat_value  = {1'b0, estat_esubcode, estat_ecode, 14'b0, estat_is_sw};
    assign eentry_value = {eentry_va, 6'b0};

    always_comb begin
        case (csr_num)
            CSR_CRMD:   csr_rvalue = crmd_value;
            CSR_PRMD:   csr_rvalue = prmd_value;
            CSR_ESTAT:  csr_rvalue = estat_value;
            CSR_ERA:    csr_rvalue = era;
            CSR_EENTRY: csr_rvalue = eentry_value;
            CSR_SAVE0:  csr_rvalue = save_r[0];
            CSR_SAVE1:  csr_rvalue = save_r[1];
            CSR_SAVE2:  csr_rvalue = save_r[2];
            CSR_SAVE3:  csr_rvalue = save_r[3];
            default:    csr_rvalue = '0;
        endcase
    end

    // old value with the masked bits replaced
    assign merged = (csr_rvalue & ~csr_wmask) | (csr_wvalue & csr_wmask);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv  <= 2'd0;
            crmd_ie   <= 1'b0;
            crmd_da   <= 1'b1;
            crmd_pg   <= 1'b0;
            crmd_datf <= 2'd0;
            crmd_datm <= 2'd0;
        end else if (ex_commit) begin
            crmd_plv <= 2'd0;
            crmd_ie  <= 1'b0;
        end else if (ertn_commit) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (csr_we && csr_num == CSR_CRMD) begin
            crmd_plv  <= merged[1:0];
            crmd_ie   <= merged[2];
            crmd_da   <= merged[3];
            crmd_pg   <= merged[4];
            crmd_datf <= merged[6:5];
            crmd_datm <= merged[8:7];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= 2'd0;
            prmd_pie  <= 1'b0;
        end else if (ex_commit) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (csr_we && csr_num == CSR_PRMD) begin
            prmd_pplv <= merged[1:0];
            prmd_pie  <= merged[2];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_is_sw    <= 2'd0;
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
        end else if (ex_commit) begin
            estat_ecode    <= ecode;
            estat_esubcode <= esubcode;
            era            <= pc;
        end else if (csr_we && csr_num == CSR_ESTAT) begin
            estat_is_sw <= merged[1:0];
        end else if (csr_we && csr_num == CSR_ERA) begin
            era <= merged;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= EENTRY_RESET[31:6];
            for (int i = 0; i < 4; i++) begin
                save_r[i] <= '0;
            end
        end else if (csr_we && csr_num == CSR_EENTRY) begin
            eentry_va <= merged[31:6];
        end else if (csr_we && csr_num[13:2] == CSR_SAVE0[13:2]) begin
            save_r[csr_num[1:0]] <= merged;
        end
    end

    assign redirect_pc = ertn_commit ? era : eentry_value;

endmodule

// ==== verilog/mem_stage.sv ====
`timescale 1ns/1ps

module mem_stage (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  commit_pkg::retire_req_t in_req,
    input  logic                    flush,
    input  logic                    wb_allowin,
    output logic                    mem_valid,
    output commit_pkg::retire_req_t mem_req
);
    import commit_pkg::*;

    logic accept;

    // room when empty or when the entry moves on this edge,
    // but nothing enters while writeback flushes
    assign in_ready = (!mem_valid || wb_allowin) && !flush;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            mem_valid <= 1'b0;
        end else if (flush) begin
            // younger instruction is squashed
            mem_valid <= 1'b0;
        end else if (in_ready) begin
            mem_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_req <= in_req;
        end
    end

endmodule

// ==== verilog/commit_pkg.sv ====
package commit_pkg;

    // widths with a meaning of their own
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_num_t;
    typedef logic [5:0]  ecode_t;
    typedef logic [8:0]  esubcode_t;

    // implemented csr numbers
    localparam csr_num_t CSR_CRMD   = 14'h0;
    localparam csr_num_t CSR_PRMD   = 14'h1;
    localparam csr_num_t CSR_ESTAT  = 14'h5;
    localparam csr_num_t CSR_ERA    = 14'h6;
    localparam csr_num_t CSR_EENTRY = 14'hc;
    localparam csr_num_t CSR_SAVE0  = 14'h30;
    localparam csr_num_t CSR_SAVE1  = 14'h31;
    localparam csr_num_t CSR_SAVE2  = 14'h32;
    localparam csr_num_t CSR_SAVE3  = 14'h33;

    // one executed instruction waiting to retire
    typedef struct packed {
        word_t     pc;
        // register result
        logic      rf_we;
        reg_addr_t rf_waddr;
        word_t     rf_result;
        // csr access
        logic      res_from_csr;
        csr_num_t  csr_num;
        logic      csr_we;
        word_t     csr_wmask;
        word_t     csr_wvalue;
        // exception and return
        logic      ertn;
        logic      excep;
        ecode_t    ecode;
        esubcode_t esubcode;
    } retire_req_t;

    // register file write port
    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        word_t     wdata;
    } rf_wr_t;

    // one record per retired instruction
    typedef struct packed {
        word_t     pc;
        logic      rf_we;
        reg_addr_t rf_wnum;
        word_t     rf_wdata;
    } trace_t;

endpackage
